//--- rtl/csr_unit_pkg.sv
`default_nettype none

package csr_unit_pkg;

   typedef logic [63:0] dword_t;
   typedef logic [38:0] vaddr_t;
   typedef logic [11:0] csr_addr_t;
   typedef logic [1:0]  priv_t;
   typedef logic [15:0] ecode_dec_t;
   typedef logic [3:0]  ecode_t;

   localparam priv_t PRIV_U = 2'd0;
   localparam priv_t PRIV_S = 2'd1;
   localparam priv_t PRIV_M = 2'd3;

   typedef enum logic [3:0] {
      e_csrrw,
      e_csrrs,
      e_csrrc,
      e_csrrwi,
      e_csrrsi,
      e_csrrci,
      e_mret,
      e_sret,
      e_exception,
      e_take_interrupt
   } csr_op_e;

   typedef enum logic [2:0] {
      e_kind_access,
      e_kind_mret,
      e_kind_sret,
      e_kind_exception,
      e_kind_interrupt
   } req_kind_e;

   typedef enum logic [1:0] {
      e_wr_write,
      e_wr_set,
      e_wr_clear
   } wr_mode_e;

   typedef struct packed {
      csr_op_e    op;
      csr_addr_t  addr;
      dword_t     data;
      vaddr_t     pc;
      vaddr_t     tval;
      ecode_dec_t ecode_dec;
   } csr_cmd_t;

   typedef struct packed {
      req_kind_e  kind;
      csr_addr_t  addr;
      dword_t     operand;
      wr_mode_e   wr_mode;
      vaddr_t     pc;
      vaddr_t     tval;
      ecode_dec_t ecode_dec;
      logic       read_only;
      priv_t      min_priv;
   } csr_req_t;

   typedef struct packed {
      dword_t rdata;
      logic   illegal;
   } csr_rsp_t;

   typedef struct packed {
      logic   exception;
      logic   interrupt;
      logic   eret;
      priv_t  priv_n;
      vaddr_t epc;
      vaddr_t tvec;
   } trap_pkt_t;

   // Write and trap-commit controls from the exec stage
   typedef struct packed {
      logic      we;
      csr_addr_t waddr;
      dword_t    wdata;
      logic      take;
      logic      to_s;
      logic      irq;
      ecode_t    cause;
      vaddr_t    epc;
      vaddr_t    tval;
      priv_t     priv;
      logic      mret;
      logic      sret;
   } csr_commit_t;

   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MISA     = 12'h301;
   localparam csr_addr_t CSR_MEDELEG  = 12'h302;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;
   localparam csr_addr_t CSR_MHARTID  = 12'hf14;
   localparam csr_addr_t CSR_SSTATUS  = 12'h100;
   localparam csr_addr_t CSR_STVEC    = 12'h105;
   localparam csr_addr_t CSR_SSCRATCH = 12'h140;
   localparam csr_addr_t CSR_SEPC     = 12'h141;
   localparam csr_addr_t CSR_SCAUSE   = 12'h142;
   localparam csr_addr_t CSR_STVAL    = 12'h143;

   // mstatus field positions
   localparam int MSTATUS_SIE  = 1;
   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_SPIE = 5;
   localparam int MSTATUS_MPIE = 7;
   localparam int MSTATUS_SPP  = 8;
   localparam int MSTATUS_MPP  = 11;

   localparam dword_t MSTATUS_WMASK = 64'h0000_0000_0000_19aa;
   localparam dword_t SSTATUS_MASK  = 64'h0000_0000_0000_0122;
   localparam dword_t MIP_WMASK     = 64'h0000_0000_0000_0222;

   // RV64 with A, I, M, S and U
   localparam dword_t MISA_VALUE = 64'h8000_0000_0014_1101;

endpackage

`default_nettype wire

//--- rtl/csr_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode_stage (
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic                    cmd_v_i,
   input  csr_unit_pkg::csr_cmd_t  cmd_i,
   output logic                    req_v_o,
   output csr_unit_pkg::csr_req_t  req_o
);

   csr_unit_pkg::csr_req_t req_d;

   always_comb
   begin
      req_d.kind      = csr_unit_pkg::e_kind_access;
      req_d.wr_mode   = csr_unit_pkg::e_wr_write;
      req_d.addr      = cmd_i.addr;
      req_d.operand   = cmd_i.data;
      req_d.pc        = cmd_i.pc;
      req_d.tval      = cmd_i.tval;
      req_d.ecode_dec = cmd_i.ecode_dec;
      req_d.min_priv  = csr_unit_pkg::priv_t'(cmd_i.addr[9:8]);
      // misa is fixed in this core, so it counts as read-only too
      req_d.read_only = (&cmd_i.addr[11:10]) || (cmd_i.addr == csr_unit_pkg::CSR_MISA);

      case (cmd_i.op)
         csr_unit_pkg::e_csrrs:
            req_d.wr_mode = csr_unit_pkg::e_wr_set;
         csr_unit_pkg::e_csrrc:
            req_d.wr_mode = csr_unit_pkg::e_wr_clear;
         csr_unit_pkg::e_csrrsi:
            req_d.wr_mode = csr_unit_pkg::e_wr_set;
         csr_unit_pkg::e_csrrci:
            req_d.wr_mode = csr_unit_pkg::e_wr_clear;
         csr_unit_pkg::e_mret:
            req_d.kind = csr_unit_pkg::e_kind_mret;
         csr_unit_pkg::e_sret:
            req_d.kind = csr_unit_pkg::e_kind_sret;
         csr_unit_pkg::e_exception:
            req_d.kind = csr_unit_pkg::e_kind_exception;
         csr_unit_pkg::e_take_interrupt:
            req_d.kind = csr_unit_pkg::e_kind_interrupt;
         default:
            req_d.kind = csr_unit_pkg::e_kind_access;
      endcase

      // Immediate forms carry a 5-bit zimm in the data field
      if (cmd_i.op inside {csr_unit_pkg::e_csrrwi, csr_unit_pkg::e_csrrsi,
                           csr_unit_pkg::e_csrrci})
      begin
         req_d.operand = csr_unit_pkg::dword_t'(cmd_i.data[4:0]);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         req_v_o <= 1'b0;
      else
         req_v_o <= cmd_v_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (cmd_v_i)
         req_o <= req_d;
   end

endmodule

`default_nettype wire

//--- rtl/csr_trap_select.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_select (
   input  csr_unit_pkg::ecode_dec_t ecode_dec_i,
   input  csr_unit_pkg::priv_t      priv_i,
   input  logic                     mstatus_mie_i,
   input  csr_unit_pkg::dword_t     mie_i,
   input  csr_unit_pkg::dword_t     mip_i,
   input  csr_unit_pkg::dword_t     medeleg_i,
   output csr_unit_pkg::ecode_t     exc_cause_o,
   output logic                     exc_v_o,
   output csr_unit_pkg::ecode_t     irq_cause_o,
   output logic                     irq_v_o,
   output logic                     delegate_o
);

   logic mei_v;
   logic msi_v;
   logic mti_v;
   logic gie;

   // Lowest set bit wins
   always_comb
   begin
      exc_cause_o = '0;
      exc_v_o     = 1'b0;
      for (int i = 15; i >= 0; i--)
      begin
         if (ecode_dec_i[i])
         begin
            exc_cause_o = csr_unit_pkg::ecode_t'(i);
            exc_v_o     = 1'b1;
         end
      end
   end

   assign mei_v = mie_i[11] & mip_i[11];
   assign msi_v = mie_i[3] & mip_i[3];
   assign mti_v = mie_i[7] & mip_i[7];

   // Always enabled below M
   assign gie = (priv_i != csr_unit_pkg::PRIV_M) || mstatus_mie_i;

   always_comb
   begin
      if (mei_v)
         irq_cause_o = 4'd11;
      else if (msi_v)
         irq_cause_o = 4'd3;
      else
         irq_cause_o = 4'd7;
   end

   assign irq_v_o = gie & (mei_v | msi_v | mti_v);

   assign delegate_o = medeleg_i[exc_cause_o] && (priv_i != csr_unit_pkg::PRIV_M);

endmodule

`default_nettype wire

//--- rtl/csr_exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module csr_exec_stage (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        req_v_i,
   input  csr_unit_pkg::csr_req_t      req_i,
   input  csr_unit_pkg::ecode_t        exc_cause_i,
   input  logic                        exc_v_i,
   input  csr_unit_pkg::ecode_t        irq_cause_i,
   input  logic                        irq_v_i,
   input  logic                        delegate_i,
   input  csr_unit_pkg::dword_t        rdata_i,
   input  logic                        known_i,
   input  csr_unit_pkg::dword_t        mstatus_i,
   input  csr_unit_pkg::dword_t        mepc_i,
   input  csr_unit_pkg::dword_t        sepc_i,
   input  csr_unit_pkg::dword_t        mtvec_i,
   input  csr_unit_pkg::dword_t        stvec_i,
   output csr_unit_pkg::csr_commit_t   commit_o,
   output logic                        rsp_v_o,
   output csr_unit_pkg::csr_rsp_t      rsp_o,
   output logic                        trap_v_o,
   output csr_unit_pkg::trap_pkt_t     trap_pkt_o,
   output csr_unit_pkg::priv_t         priv_mode_o,
   output logic                        irq_pending_o
);

   csr_unit_pkg::priv_t     priv_n;
   csr_unit_pkg::csr_rsp_t  rsp_n;
   csr_unit_pkg::trap_pkt_t trap_n;
   logic                    illegal;
   logic                    is_write;

   // Set or clear with a zero operand is only a read
   assign is_write = (req_i.wr_mode == csr_unit_pkg::e_wr_write) || (req_i.operand != '0);

   always_comb
   begin
      priv_n         = priv_mode_o;
      illegal        = 1'b0;
      trap_n         = '0;
      commit_o       = '0;
      commit_o.waddr = req_i.addr;
      commit_o.epc   = req_i.pc;
      commit_o.tval  = req_i.tval;
      commit_o.priv  = priv_mode_o;

      case (req_i.wr_mode)
         csr_unit_pkg::e_wr_set:
            commit_o.wdata = rdata_i | req_i.operand;
         csr_unit_pkg::e_wr_clear:
            commit_o.wdata = rdata_i & ~req_i.operand;
         default:
            commit_o.wdata = req_i.operand;
      endcase

      if (req_v_i)
      begin
         case (req_i.kind)
            csr_unit_pkg::e_kind_access:
            begin
               illegal = (priv_mode_o < req_i.min_priv) || !known_i
                         || (req_i.read_only && is_write);
               commit_o.we = !illegal;
            end
            csr_unit_pkg::e_kind_mret:
            begin
               illegal = (priv_mode_o != csr_unit_pkg::PRIV_M);
               if (!illegal)
               begin
                  commit_o.mret = 1'b1;
                  priv_n        = mstatus_i[csr_unit_pkg::MSTATUS_MPP +: 2];
                  trap_n.eret   = 1'b1;
               end
            end
            csr_unit_pkg::e_kind_sret:
            begin
               illegal = (priv_mode_o == csr_unit_pkg::PRIV_U);
               if (!illegal)
               begin
                  commit_o.sret = 1'b1;
                  priv_n        = {1'b0, mstatus_i[csr_unit_pkg::MSTATUS_SPP]};
                  trap_n.eret   = 1'b1;
               end
            end
            csr_unit_pkg::e_kind_exception:
            begin
               if (exc_v_i)
               begin
                  commit_o.take    = 1'b1;
                  commit_o.to_s    = delegate_i;
                  commit_o.cause   = exc_cause_i;
                  priv_n           = delegate_i ? csr_unit_pkg::PRIV_S : csr_unit_pkg::PRIV_M;
                  trap_n.exception = 1'b1;
               end
            end
            csr_unit_pkg::e_kind_interrupt:
            begin
               if (irq_v_i)
               begin
                  commit_o.take    = 1'b1;
                  commit_o.irq     = 1'b1;
                  commit_o.cause   = irq_cause_i;
                  commit_o.tval    = '0;
                  priv_n           = csr_unit_pkg::PRIV_M;
                  trap_n.interrupt = 1'b1;
               end
            end
            default:
               illegal = 1'b1;
         endcase
      end

      trap_n.priv_n = priv_n;
      trap_n.epc    = csr_unit_pkg::vaddr_t'(commit_o.sret ? sepc_i : mepc_i);
      trap_n.tvec   = csr_unit_pkg::vaddr_t'((priv_n == csr_unit_pkg::PRIV_S) ? stvec_i
                                                                               : mtvec_i);

      rsp_n.illegal = illegal;
      rsp_n.rdata   = commit_o.we ? rdata_i : '0;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rsp_v_o       <= 1'b0;
         trap_v_o      <= 1'b0;
         irq_pending_o <= 1'b0;
         priv_mode_o   <= csr_unit_pkg::PRIV_M;
      end
      else
      begin
         rsp_v_o       <= req_v_i;
         trap_v_o      <= trap_n.exception | trap_n.interrupt | trap_n.eret;
         irq_pending_o <= irq_v_i;
         priv_mode_o   <= priv_n;
      end
   end

   always_ff @(posedge clk_i)
   begin
      rsp_o      <= rsp_n;
      trap_pkt_o <= trap_n;
   end

endmodule

`default_nettype wire

//--- rtl/csr_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_reg_file #(
   parameter int unsigned hart_id_p = 0
) (
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  csr_unit_pkg::csr_commit_t   commit_i,
   input  logic                        timer_irq_i,
   input  logic                        software_irq_i,
   input  logic                        external_irq_i,
   input  csr_unit_pkg::csr_addr_t     raddr_i,
   output csr_unit_pkg::dword_t        rdata_o,
   output logic                        known_o,
   output csr_unit_pkg::dword_t        mstatus_o,
   output csr_unit_pkg::dword_t        mie_o,
   output csr_unit_pkg::dword_t        mip_o,
   output csr_unit_pkg::dword_t        medeleg_o,
   output csr_unit_pkg::dword_t        mepc_o,
   output csr_unit_pkg::dword_t        sepc_o,
   output csr_unit_pkg::dword_t        mtvec_o,
   output csr_unit_pkg::dword_t        stvec_o
);

   csr_unit_pkg::dword_t mscratch_r;
   csr_unit_pkg::dword_t mcause_r;
   csr_unit_pkg::dword_t mtval_r;
   csr_unit_pkg::dword_t sscratch_r;
   csr_unit_pkg::dword_t scause_r;
   csr_unit_pkg::dword_t stval_r;
   csr_unit_pkg::dword_t cause_n;
   csr_unit_pkg::dword_t wdata;

   assign cause_n = {commit_i.irq, 59'd0, commit_i.cause};
   assign wdata   = commit_i.wdata;

   always_comb
   begin
      rdata_o = '0;
      known_o = 1'b1;
      case (raddr_i)
         csr_unit_pkg::CSR_MSTATUS:  rdata_o = mstatus_o;
         csr_unit_pkg::CSR_MISA:     rdata_o = csr_unit_pkg::MISA_VALUE;
         csr_unit_pkg::CSR_MEDELEG:  rdata_o = medeleg_o;
         csr_unit_pkg::CSR_MIE:      rdata_o = mie_o;
         csr_unit_pkg::CSR_MTVEC:    rdata_o = mtvec_o;
         csr_unit_pkg::CSR_MSCRATCH: rdata_o = mscratch_r;
         csr_unit_pkg::CSR_MEPC:     rdata_o = mepc_o;
         csr_unit_pkg::CSR_MCAUSE:   rdata_o = mcause_r;
         csr_unit_pkg::CSR_MTVAL:    rdata_o = mtval_r;
         csr_unit_pkg::CSR_MIP:      rdata_o = mip_o;
         csr_unit_pkg::CSR_MHARTID:  rdata_o = csr_unit_pkg::dword_t'(hart_id_p);
         csr_unit_pkg::CSR_SSTATUS:  rdata_o = mstatus_o & csr_unit_pkg::SSTATUS_MASK;
         csr_unit_pkg::CSR_STVEC:    rdata_o = stvec_o;
         csr_unit_pkg::CSR_SSCRATCH: rdata_o = sscratch_r;
         csr_unit_pkg::CSR_SEPC:     rdata_o = sepc_o;
         csr_unit_pkg::CSR_SCAUSE:   rdata_o = scause_r;
         csr_unit_pkg::CSR_STVAL:    rdata_o = stval_r;
         default:                    known_o = 1'b0;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         mstatus_o  <= '0;
         medeleg_o  <= '0;
         mie_o      <= '0;
         mip_o      <= '0;
         mtvec_o    <= '0;
         mscratch_r <= '0;
         mepc_o     <= '0;
         mcause_r   <= '0;
         mtval_r    <= '0;
         stvec_o    <= '0;
         sscratch_r <= '0;
         sepc_o     <= '0;
         scause_r   <= '0;
         stval_r    <= '0;
      end
      else
      begin
         if (commit_i.take && commit_i.to_s)
         begin
            sepc_o   <= csr_unit_pkg::dword_t'(commit_i.epc);
            stval_r  <= csr_unit_pkg::dword_t'(commit_i.tval);
            scause_r <= cause_n;
            mstatus_o[csr_unit_pkg::MSTATUS_SPP]  <= commit_i.priv[0];
            mstatus_o[csr_unit_pkg::MSTATUS_SPIE] <= mstatus_o[csr_unit_pkg::MSTATUS_SIE];
            mstatus_o[csr_unit_pkg::MSTATUS_SIE]  <= 1'b0;
         end
         else if (commit_i.take)
         begin
            mepc_o   <= csr_unit_pkg::dword_t'(commit_i.epc);
            mtval_r  <= csr_unit_pkg::dword_t'(commit_i.tval);
            mcause_r <= cause_n;
            mstatus_o[csr_unit_pkg::MSTATUS_MPP +: 2] <= commit_i.priv;
            mstatus_o[csr_unit_pkg::MSTATUS_MPIE]     <= mstatus_o[csr_unit_pkg::MSTATUS_MIE];
            mstatus_o[csr_unit_pkg::MSTATUS_MIE]      <= 1'b0;
         end
         else if (commit_i.mret)
         begin
            mstatus_o[csr_unit_pkg::MSTATUS_MIE]      <= mstatus_o[csr_unit_pkg::MSTATUS_MPIE];
            mstatus_o[csr_unit_pkg::MSTATUS_MPIE]     <= 1'b1;
            mstatus_o[csr_unit_pkg::MSTATUS_MPP +: 2] <= csr_unit_pkg::PRIV_U;
         end
         else if (commit_i.sret)
         begin
            mstatus_o[csr_unit_pkg::MSTATUS_SIE]  <= mstatus_o[csr_unit_pkg::MSTATUS_SPIE];
            mstatus_o[csr_unit_pkg::MSTATUS_SPIE] <= 1'b1;
            mstatus_o[csr_unit_pkg::MSTATUS_SPP]  <= 1'b0;
         end
         else if (commit_i.we)
         begin
            case (commit_i.waddr)
               csr_unit_pkg::CSR_MSTATUS:
                  mstatus_o <= wdata & csr_unit_pkg::MSTATUS_WMASK;
               csr_unit_pkg::CSR_SSTATUS:
                  mstatus_o <= (mstatus_o & ~csr_unit_pkg::SSTATUS_MASK)
                               | (wdata & csr_unit_pkg::SSTATUS_MASK);
               csr_unit_pkg::CSR_MEDELEG:  medeleg_o  <= wdata;
               csr_unit_pkg::CSR_MIE:      mie_o      <= wdata;
               csr_unit_pkg::CSR_MTVEC:    mtvec_o    <= wdata;
               csr_unit_pkg::CSR_MSCRATCH: mscratch_r <= wdata;
               csr_unit_pkg::CSR_MEPC:     mepc_o     <= wdata;
               csr_unit_pkg::CSR_MCAUSE:   mcause_r   <= wdata;
               csr_unit_pkg::CSR_MTVAL:    mtval_r    <= wdata;
               csr_unit_pkg::CSR_MIP:
                  mip_o <= (mip_o & ~csr_unit_pkg::MIP_WMASK) | (wdata & csr_unit_pkg::MIP_WMASK);
               csr_unit_pkg::CSR_STVEC:    stvec_o    <= wdata;
               csr_unit_pkg::CSR_SSCRATCH: sscratch_r <= wdata;
               csr_unit_pkg::CSR_SEPC:     sepc_o     <= wdata;
               csr_unit_pkg::CSR_SCAUSE:   scause_r   <= wdata;
               csr_unit_pkg::CSR_STVAL:    stval_r    <= wdata;
               default: ;
            endcase
         end

         // M-level pending bits follow the pins every cycle
         mip_o[7]  <= timer_irq_i;
         mip_o[3]  <= software_irq_i;
         mip_o[11] <= external_irq_i;
      end
   end

endmodule

`default_nettype wire

//--- rtl/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
   parameter int unsigned hart_id_p = 0
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     cmd_v_i,
   input  csr_unit_pkg::csr_cmd_t   cmd_i,
   input  logic                     timer_irq_i,
   input  logic                     software_irq_i,
   input  logic                     external_irq_i,
   output logic                     rsp_v_o,
   output csr_unit_pkg::csr_rsp_t   rsp_o,
   output logic                     trap_v_o,
   output csr_unit_pkg::trap_pkt_t  trap_pkt_o,
   output csr_unit_pkg::priv_t      priv_mode_o,
   output logic                     irq_pending_o
);

   logic                      req_v;
   csr_unit_pkg::csr_req_t    req;
   csr_unit_pkg::csr_commit_t commit;
   csr_unit_pkg::dword_t      rdata;
   logic                      known;
   csr_unit_pkg::dword_t      mstatus;
   csr_unit_pkg::dword_t      mie;
   csr_unit_pkg::dword_t      mip;
   csr_unit_pkg::dword_t      medeleg;
   csr_unit_pkg::dword_t      mepc;
   csr_unit_pkg::dword_t      sepc;
   csr_unit_pkg::dword_t      mtvec;
   csr_unit_pkg::dword_t      stvec;
   csr_unit_pkg::ecode_t      exc_cause;
   logic                      exc_v;
   csr_unit_pkg::ecode_t      irq_cause;
   logic                      irq_v;
   logic                      delegate;

   csr_decode_stage decode0 (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .cmd_v_i  (cmd_v_i),
      .cmd_i    (cmd_i),
      .req_v_o  (req_v),
      .req_o    (req)
   );

   csr_trap_select trap_sel0 (
      .ecode_dec_i   (req.ecode_dec),
      .priv_i        (priv_mode_o),
      .mstatus_mie_i (mstatus[csr_unit_pkg::MSTATUS_MIE]),
      .mie_i         (mie),
      .mip_i         (mip),
      .medeleg_i     (medeleg),
      .exc_cause_o   (exc_cause),
      .exc_v_o       (exc_v),
      .irq_cause_o   (irq_cause),
      .irq_v_o       (irq_v),
      .delegate_o    (delegate)
   );

   csr_exec_stage exec0 (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_v_i       (req_v),
      .req_i         (req),
      .exc_cause_i   (exc_cause),
      .exc_v_i       (exc_v),
      .irq_cause_i   (irq_cause),
      .irq_v_i       (irq_v),
      .delegate_i    (delegate),
      .rdata_i       (rdata),
      .known_i       (known),
      .mstatus_i     (mstatus),
      .mepc_i        (mepc),
      .sepc_i        (sepc),
      .mtvec_i       (mtvec),
      .stvec_i       (stvec),
      .commit_o      (commit),
      .rsp_v_o       (rsp_v_o),
      .rsp_o         (rsp_o),
      .trap_v_o      (trap_v_o),
      .trap_pkt_o    (trap_pkt_o),
      .priv_mode_o   (priv_mode_o),
      .irq_pending_o (irq_pending_o)
   );

   csr_reg_file #(
      .hart_id_p (hart_id_p)
   ) regs0 (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .commit_i       (commit),
      .timer_irq_i    (timer_irq_i),
      .software_irq_i (software_irq_i),
      .external_irq_i (external_irq_i),
      .raddr_i        (req.addr),
      .rdata_o        (rdata),
      .known_o        (known),
      .mstatus_o      (mstatus),
      .mie_o          (mie),
      .mip_o          (mip),
      .medeleg_o      (medeleg),
      .mepc_o         (mepc),
      .sepc_o         (sepc),
      .mtvec_o        (mtvec),
      .stvec_o        (stvec)
   );

endmodule

`default_nettype wire

//--- tests/csr_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_asserts (
   input logic                    clk_i,
   input logic                    arst_n_i,
   input logic                    cmd_v_i,
   input logic                    rsp_v_i,
   input logic                    trap_v_i,
   input csr_unit_pkg::trap_pkt_t trap_pkt_i,
   input logic                    irq_pending_i
);

   // Registered outputs stay quiet in reset
   reset_quiet_a: assert property (@(posedge clk_i)
      !arst_n_i |-> (!rsp_v_i && !trap_v_i && !irq_pending_i))
      else $error("outputs active while reset is asserted");

   trap_kind_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      trap_v_i |-> !(trap_pkt_i.exception && trap_pkt_i.interrupt))
      else $error("trap packet flags exception and interrupt together");

   // Two-stage pipeline latency
   rsp_latency_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_v_i == $past(cmd_v_i, 2))
      else $error("rsp_v_o does not follow cmd_v_i by two cycles");

endmodule

bind csr_unit csr_unit_asserts asserts0 (
   .clk_i         (clk_i),
   .arst_n_i      (arst_n_i),
   .cmd_v_i       (cmd_v_i),
   .rsp_v_i       (rsp_v_o),
   .trap_v_i      (trap_v_o),
   .trap_pkt_i    (trap_pkt_o),
   .irq_pending_i (irq_pending_o)
);

`default_nettype wire

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

   localparam int max_vec_c = 64;

   typedef struct packed {
      logic [3:0]               op;
      csr_unit_pkg::csr_addr_t  addr;
      csr_unit_pkg::dword_t     data;
      csr_unit_pkg::vaddr_t     pc;
      csr_unit_pkg::ecode_dec_t ecode_dec;
      logic [2:0]               irq;
      csr_unit_pkg::dword_t     rdata;
      logic                     illegal;
      logic [2:0]               trap;
      csr_unit_pkg::priv_t      priv;
      csr_unit_pkg::vaddr_t     tvec;
      csr_unit_pkg::vaddr_t     epc;
      logic                     irq_pending;
   } vector_t;

   logic                    clk = 1'b0;
   logic                    arst_n;
   logic                    cmd_v;
   csr_unit_pkg::csr_cmd_t  cmd;
   logic                    timer_irq;
   logic                    software_irq;
   logic                    external_irq;
   logic                    rsp_v;
   csr_unit_pkg::csr_rsp_t  rsp;
   logic                    trap_v;
   csr_unit_pkg::trap_pkt_t trap_pkt;
   csr_unit_pkg::priv_t     priv_mode;
   logic                    irq_pending;

   vector_t vecs [max_vec_c];
   string   names [max_vec_c];
   int      n_vec;
   int      pass_cnt = 0;
   int      fail_cnt = 0;
   int      cycle_cnt = 0;
   int      cycle_limit = 100;
   int      waited;

   csr_unit #(
      .hart_id_p (5)
   ) dut0 (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .cmd_v_i        (cmd_v),
      .cmd_i          (cmd),
      .timer_irq_i    (timer_irq),
      .software_irq_i (software_irq),
      .external_irq_i (external_irq),
      .rsp_v_o        (rsp_v),
      .rsp_o          (rsp),
      .trap_v_o       (trap_v),
      .trap_pkt_o     (trap_pkt),
      .priv_mode_o    (priv_mode),
      .irq_pending_o  (irq_pending)
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Comment lines start with '#'
   task automatic read_vectors(output int count);
      int          fd;
      int          rc;
      string       line;
      string       name;
      logic [63:0] f [13];
      count = 0;
      fd = $fopen("tests/csr_unit_input.txt", "r");
      if (fd == 0)
      begin
         count = -1;
      end
      else
      begin
         while (!$feof(fd) && count < max_vec_c)
         begin
            line = "";
            rc = $fgets(line, fd);
            if (rc != 0 && line.len() > 1 && line.getc(0) != "#")
            begin
               rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12]);
               if (rc != 14)
               begin
                  $display("malformed vector line: %s", line);
                  fail_cnt++;
               end
               else
               begin
                  names[count]            = name;
                  vecs[count].op          = f[0][3:0];
                  vecs[count].addr        = f[1][11:0];
                  vecs[count].data        = f[2];
                  vecs[count].pc          = f[3][38:0];
                  vecs[count].ecode_dec   = f[4][15:0];
                  vecs[count].irq         = f[5][2:0];
                  vecs[count].rdata       = f[6];
                  vecs[count].illegal     = f[7][0];
                  vecs[count].trap        = f[8][2:0];
                  vecs[count].priv        = f[9][1:0];
                  vecs[count].tvec        = f[10][38:0];
                  vecs[count].epc         = f[11][38:0];
                  vecs[count].irq_pending = f[12][0];
                  count++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic drive_cmd(input vector_t v);
      @(posedge clk);
      #1;
      cmd_v         = 1'b1;
      cmd.op        = csr_unit_pkg::csr_op_e'(v.op);
      cmd.addr      = v.addr;
      cmd.data      = v.data;
      cmd.pc        = v.pc;
      cmd.tval      = '0;
      cmd.ecode_dec = v.ecode_dec;
      timer_irq     = v.irq[0];
      software_irq  = v.irq[1];
      external_irq  = v.irq[2];
      @(posedge clk);
      #1;
      cmd_v = 1'b0;
   endtask

   // Outputs are sampled on the falling edge
   task automatic wait_rsp(output int cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      while (!seen)
      begin
         @(negedge clk);
         cycles++;
         seen = rsp_v;
      end
   endtask

   task automatic report_mismatch(input string name, input string field,
                                  input logic [63:0] expected, input logic [63:0] actual);
      fail_cnt++;
      $display("** Error %s: %s expected %h actual %h", name, field, expected, actual);
   endtask

   task automatic check_rsp(input string name, input vector_t v);
      logic [2:0] flags;
      flags = {trap_pkt.exception, trap_pkt.interrupt, trap_pkt.eret};
      if (rsp.rdata !== v.rdata)
         report_mismatch(name, "rdata", v.rdata, rsp.rdata);
      else if (rsp.illegal !== v.illegal)
         report_mismatch(name, "illegal", v.illegal, rsp.illegal);
      else if (trap_v !== (|v.trap))
         report_mismatch(name, "trap_v", |v.trap, trap_v);
      else if (flags !== v.trap)
         report_mismatch(name, "trap flags", v.trap, flags);
      else if (priv_mode !== v.priv)
         report_mismatch(name, "priv_mode", v.priv, priv_mode);
      else if ((|v.trap) && trap_pkt.priv_n !== v.priv)
         report_mismatch(name, "priv_n", v.priv, trap_pkt.priv_n);
      else if ((|v.trap) && trap_pkt.tvec !== v.tvec)
         report_mismatch(name, "tvec", v.tvec, trap_pkt.tvec);
      else if (v.trap[0] && trap_pkt.epc !== v.epc)
         report_mismatch(name, "epc", v.epc, trap_pkt.epc);
      else if (irq_pending !== v.irq_pending)
         report_mismatch(name, "irq_pending", v.irq_pending, irq_pending);
      else
      begin
         pass_cnt++;
         $display("ok    %s", name);
      end
   endtask

   initial
   begin
      arst_n       = 1'b0;
      cmd_v        = 1'b0;
      cmd          = '0;
      timer_irq    = 1'b0;
      software_irq = 1'b0;
      external_irq = 1'b0;
      read_vectors(n_vec);
      if (n_vec <= 0)
      begin
         $display("no test vectors could be read from tests/csr_unit_input.txt");
         $display("TESTBENCH FAILED");
         $finish;
      end
      else
      begin
         cycle_limit = n_vec * 4 + 100;
         repeat (15) @(posedge clk);
         @(negedge clk);
         if (rsp_v !== 1'b0 || trap_v !== 1'b0 || irq_pending !== 1'b0)
         begin
            $display("outputs are not low while reset is asserted");
            fail_cnt++;
         end
         @(posedge clk);
         #1;
         arst_n = 1'b1;

         for (int i = 0; i < n_vec; i++)
         begin
            drive_cmd(vecs[i]);
            wait_rsp(waited);
            if (waited != 2)
            begin
               $display("response for %s arrived %0d cycles after the command instead of 2",
                        names[i], waited);
               fail_cnt++;
            end
            else
               check_rsp(names[i], vecs[i]);
         end

         $display("tests %0d  passed %0d  failed %0d", n_vec, pass_cnt, fail_cnt);
         if (fail_cnt == 0 && pass_cnt == n_vec)
            $display("TESTBENCH PASSED");
         else
            $display("TESTBENCH FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- csr_unit.f
rtl/csr_unit_pkg.sv
rtl/csr_decode_stage.sv
rtl/csr_trap_select.sv
rtl/csr_exec_stage.sv
rtl/csr_reg_file.sv
rtl/csr_unit.sv
tests/csr_unit_asserts.sv
tests/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - rtl/csr_unit_pkg.sv
  - rtl/csr_decode_stage.sv
  - rtl/csr_trap_select.sv
  - rtl/csr_exec_stage.sv
  - rtl/csr_reg_file.sv
  - rtl/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_asserts.sv
      - tests/csr_unit_tb.sv

//--- tests/csr_unit_input.txt
# name op addr data pc ecode_dec irq(bit0 timer, bit1 sw, bit2 ext), then expected values:
# rdata illegal trap(4 exc, 2 irq, 1 eret) priv tvec(on traps) epc(on returns) irq_pending; hex
reset_hartid 1 f14 0 0 0 0 5 0 0 3 0 0 0
scr_rw 0 340 123456789abcdef0 0 0 0 0 0 0 3 0 0 0
scr_rs 1 340 f 0 0 0 123456789abcdef0 0 0 3 0 0 0
scr_rc 2 340 ff00 0 0 0 123456789abcdeff 0 0 3 0 0 0
scr_rwi 3 340 ffffffffffffffe3 0 0 0 123456789abc00ff 0 0 3 0 0 0
scr_rsi 4 340 1c 0 0 0 3 0 0 3 0 0 0
scr_rci 5 340 25 0 0 0 1f 0 0 3 0 0 0
scr_read 1 340 0 0 0 0 1a 0 0 3 0 0 0
ill_unknown 1 7c0 0 0 0 0 0 1 0 3 0 0 0
ill_misa_wr 0 301 0 0 0 0 0 1 0 3 0 0 0
misa_set0 1 301 0 0 0 0 8000000000141101 0 0 3 0 0 0
mtvec_wr 0 305 80000100 0 0 0 0 0 0 3 0 0 0
stvec_wr 0 105 80000200 0 0 0 0 0 0 3 0 0 0
exc_m 8 0 0 1000 4 0 0 0 4 3 80000100 0 0
mcause_rd 1 342 0 0 0 0 2 0 0 3 0 0 0
mepc_rd 1 341 0 0 0 0 1000 0 0 3 0 0 0
medeleg_wr 0 302 100 0 0 0 0 0 0 3 0 0 0
mstatus_clr 0 300 0 0 0 0 1800 0 0 3 0 0 0
mepc_wr 0 341 2000 0 0 0 1000 0 0 3 0 0 0
mret_to_u 6 0 0 0 0 0 0 0 1 0 80000100 2000 0
ill_mstatus_u 1 300 0 0 0 0 0 1 0 0 0 0 0
ill_sret_u 7 0 0 0 0 0 0 1 0 0 0 0 0
exc_u_deleg 8 0 0 3000 100 0 0 0 4 1 80000200 0 0
sstatus_rd 1 100 0 0 0 0 0 0 0 1 0 0 0
scause_rd 1 142 0 0 0 0 8 0 0 1 0 0 0
sepc_rd 1 141 0 0 0 0 3000 0 0 1 0 0 0
sret_to_u 7 0 0 0 0 0 0 0 1 0 80000100 3000 0
exc_u_m 8 0 0 4000 4 0 0 0 4 3 80000100 0 0
mie_wr 0 304 80 0 0 0 0 0 0 3 0 0 0
mstatus_mie 1 300 8 0 0 0 20 0 0 3 0 0 0
irq_raise 1 344 0 0 0 1 80 0 0 3 0 0 1
take_irq 9 0 0 5000 0 1 0 0 2 3 80000100 0 1
mcause_irq 1 342 0 0 0 1 8000000000000007 0 0 3 0 0 0
mepc_irq 1 341 0 0 0 0 5000 0 0 3 0 0 0
